//--- common/graphics_params.svh
/* Frame geometry, blanking and sync widths, and palette size
   for the display graphics subsystem. */
`ifndef GRAPHICS_PARAMS_SVH
`define GRAPHICS_PARAMS_SVH

`define FRAME_WIDTH 16      // Active pixels per line.
`define FRAME_HEIGHT 8      // Active lines per frame.
`define PIXEL_ADDR_BITS 7   // Enough bits for FRAME_WIDTH * FRAME_HEIGHT.

`define H_BLANK 6           // Blank slots after each active line.
`define HSYNC_SLOTS 2       // Leading blank slots with hsync high.

`define V_BLANK_LINES 2     // Blank lines after the active frame.
`define VSYNC_LINES 1       // Leading blank lines with vsync high.

`define PALETTE_SIZE 16

`endif

//--- common/graphics_pkg.sv
/* Command opcodes and the packed structs passed between the graphics blocks. */
`include "graphics_params.svh"

package graphics_pkg;

    localparam logic [7:0] OP_ASSIGN_COLOR = 8'h10;
    localparam logic [7:0] OP_SHOW_BUFFER = 8'h17;
    localparam logic [7:0] OP_DRAW_PIXEL = 8'h19;

    typedef struct packed {
        logic [3:0] y;
        logic [2:0] cb;
        logic [2:0] cr;
    } ycbcr_t;

    typedef struct packed {
        logic                        valid;
        logic [`PIXEL_ADDR_BITS-1:0] address;  // Row-major address y * FRAME_WIDTH + x.
        logic [3:0]                  index;
    } pixel_write_t;

    typedef struct packed {
        logic       valid;
        logic [3:0] index;
        ycbcr_t     color;
    } color_assign_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic [3:0] y;
        logic [2:0] cb;
        logic [2:0] cr;
    } display_pins_t;

endpackage

//--- display_buffers/buffer_bank.sv
/* One pixel memory bank with a synchronous write port and a registered read port. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module buffer_bank (
    input  logic                        clock_in,
    input  logic                        write_enable,
    input  logic [`PIXEL_ADDR_BITS-1:0] write_address,
    input  logic [3:0]                  write_index,
    input  logic [`PIXEL_ADDR_BITS-1:0] read_address,
    output logic [3:0]                  read_index
);

    localparam int DEPTH = `FRAME_WIDTH * `FRAME_HEIGHT;

    logic [3:0] memory [DEPTH];  // Palette indices, row-major.

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            memory[write_address] <= write_index;
        end
        read_index <= memory[read_address];  // One cycle of read latency.
    end

endmodule

//--- display_buffers/display_buffers.sv
/* Double frame buffer with front/back selection and a swap that waits
   for the next frame start. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module display_buffers import graphics_pkg::*; (
    input  logic                        clock_in,
    input  logic                        rst_n,
    input  pixel_write_t                pixel_write,
    input  logic                        show_request,
    input  logic                        frame_start,
    input  logic [`PIXEL_ADDR_BITS-1:0] read_address,
    output logic [3:0]                  read_index
);

    logic       front_select;   // Bank currently scanned out.
    logic       swap_pending;
    logic       read_select;    // Front selection aligned with the registered read.
    logic [3:0] bank_index [2];

    for (genvar bank = 0; bank < 2; bank++) begin : g_bank
        buffer_bank i_buffer_bank (
            .clock_in,
            .write_enable(pixel_write.valid && front_select != 1'(bank)),
            .write_address(pixel_write.address),
            .write_index(pixel_write.index),
            .read_address,
            .read_index(bank_index[bank])
        );
    end

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            front_select <= 1'b0;
            swap_pending <= 1'b0;
            read_select <= 1'b0;
        end else begin
            read_select <= front_select;
            if (frame_start && swap_pending) begin
                front_select <= ~front_select;
                swap_pending <= show_request;  // A show in the same clock waits a frame.
            end else if (show_request) begin
                swap_pending <= 1'b1;
            end
        end
    end

    assign read_index = bank_index[read_select];

endmodule

//--- display_driver/display_driver.sv
/* Raster timing generator producing read addresses, the frame start strobe
   and the display pins. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module display_driver import graphics_pkg::*; (
    input  logic                        clock_in,
    input  logic                        rst_n,
    input  ycbcr_t                      pixel_color,
    output logic [`PIXEL_ADDR_BITS-1:0] read_address,
    output logic                        frame_start,
    output logic                        display_clock,
    output display_pins_t               display_pins
);

    localparam int H_TOTAL = `FRAME_WIDTH + `H_BLANK;
    localparam int V_TOTAL = `FRAME_HEIGHT + `V_BLANK_LINES;
    localparam int H_BITS = $clog2(H_TOTAL);
    localparam int V_BITS = $clog2(V_TOTAL);
    localparam int ADDR_BITS = `PIXEL_ADDR_BITS;

    typedef struct packed {
        logic phase;
        logic active;
        logic hsync;
        logic vsync;
        logic frame;
    } timing_t;

    logic              phase;      // Low half of a slot when 0, high half when 1.
    logic [H_BITS-1:0] h_count;
    logic [V_BITS-1:0] v_count;
    timing_t           timing;
    timing_t           stage_1;
    timing_t           stage_2;    // Lines up with the palette output.

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 1'b0;
            h_count <= '0;
            v_count <= '0;
        end else begin
            phase <= ~phase;
            if (phase) begin
                if (h_count == H_BITS'(H_TOTAL - 1)) begin
                    h_count <= '0;
                    if (v_count == V_BITS'(V_TOTAL - 1)) begin
                        v_count <= '0;
                    end else begin
                        v_count <= v_count + 1'b1;
                    end
                end else begin
                    h_count <= h_count + 1'b1;
                end
            end
        end
    end

    assign timing.phase = phase;
    assign timing.active = h_count < H_BITS'(`FRAME_WIDTH) && v_count < V_BITS'(`FRAME_HEIGHT);
    assign timing.hsync = h_count >= H_BITS'(`FRAME_WIDTH)
                       && h_count < H_BITS'(`FRAME_WIDTH + `HSYNC_SLOTS);
    assign timing.vsync = v_count >= V_BITS'(`FRAME_HEIGHT)
                       && v_count < V_BITS'(`FRAME_HEIGHT + `VSYNC_LINES);
    assign timing.frame = v_count == V_BITS'(`FRAME_HEIGHT) && h_count == '0 && !phase;

    // The address is held for both clocks of its slot.
    assign read_address = timing.active
                        ? ADDR_BITS'(v_count) * ADDR_BITS'(`FRAME_WIDTH) + ADDR_BITS'(h_count)
                        : '0;

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            stage_1 <= '0;
            stage_2 <= '0;
        end else begin
            stage_1 <= timing;   // Covers the buffer read.
            stage_2 <= stage_1;  // Covers the palette lookup.
        end
    end

    assign frame_start = stage_2.frame;
    assign display_clock = stage_2.phase;
    assign display_pins.hsync = stage_2.hsync;
    assign display_pins.vsync = stage_2.vsync;
    assign display_pins.y = stage_2.active ? pixel_color.y : '0;
    assign display_pins.cb = stage_2.active ? pixel_color.cb : '0;
    assign display_pins.cr = stage_2.active ? pixel_color.cr : '0;

endmodule

//--- files.f
+incdir+common
common/graphics_pkg.sv
hw/command_decoder.sv
display_buffers/buffer_bank.sv
display_buffers/display_buffers.sv
hw/color_palette.sv
display_driver/display_driver.sv
hw/graphics.sv
testbench/graphics_sva.sv
testbench/graphics_tb.sv

//--- hw/color_palette.sv
/* Sixteen-entry YCbCr palette with a registered lookup. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module color_palette import graphics_pkg::*; (
    input  logic          clock_in,
    input  logic          rst_n,
    input  color_assign_t color_assign,
    input  logic [3:0]    pixel_index,
    output ycbcr_t        pixel_color
);

    ycbcr_t entries [`PALETTE_SIZE];

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PALETTE_SIZE; i++) begin
                entries[i] <= '0;   // Every index shows black after reset.
            end
            pixel_color <= '0;
        end else begin
            if (color_assign.valid) begin
                entries[color_assign.index] <= color_assign.color;
            end
            // A lookup in the same clock as a write sees the old colour.
            pixel_color <= entries[pixel_index];
        end
    end

endmodule

//--- hw/command_decoder.sv
/* Command decoder turning opcode and operand strobes into pixel-write,
   colour-assign and show strobes. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module command_decoder import graphics_pkg::*; (
    input  logic          clock_in,
    input  logic          rst_n,
    input  logic [7:0]    op_code,
    input  logic          op_code_valid,
    input  logic [7:0]    operand,
    input  logic          operand_valid,
    input  logic [7:0]    operand_count,
    output pixel_write_t  pixel_write,
    output color_assign_t color_assign,
    output logic          show_request
);

    logic [15:0] address_bytes;    // High byte arrives first.
    logic [3:0]  assign_index;
    logic [3:0]  assign_y;
    logic [2:0]  assign_cb;
    logic        op_code_valid_q;
    logic        draw_operand;
    logic        assign_operand;

    assign draw_operand = op_code_valid && operand_valid && op_code == OP_DRAW_PIXEL;
    assign assign_operand = op_code_valid && operand_valid && op_code == OP_ASSIGN_COLOR;

    always_ff @(posedge clock_in) begin
        if (draw_operand && operand_count == 8'd1) begin
            address_bytes[15:8] <= operand;
        end
        if (draw_operand && operand_count == 8'd2) begin
            address_bytes[7:0] <= operand;
        end
        if (assign_operand && operand_count == 8'd1) begin
            assign_index <= operand[3:0];
        end
        if (assign_operand && operand_count == 8'd2) begin
            assign_y <= operand[7:4];  // Colour fields use the top bits of the byte.
        end
        if (assign_operand && operand_count == 8'd3) begin
            assign_cb <= operand[7:5];
        end
    end

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            pixel_write <= '0;
            color_assign <= '0;
            show_request <= 1'b0;
            op_code_valid_q <= 1'b0;
        end else begin
            pixel_write.valid <= 1'b0;   // Strobes last a single cycle.
            color_assign.valid <= 1'b0;
            op_code_valid_q <= op_code_valid;
            // Only the rising edge counts, however long the opcode is held.
            show_request <= op_code_valid && !op_code_valid_q && op_code == OP_SHOW_BUFFER;

            if (draw_operand && operand_count == 8'd3) begin
                pixel_write <= '{
                    valid: 1'b1,
                    address: address_bytes[`PIXEL_ADDR_BITS-1:0],
                    index: operand[3:0]
                };
            end

            if (assign_operand && operand_count == 8'd4) begin
                color_assign <= '{
                    valid: 1'b1,
                    index: assign_index,
                    color: '{y: assign_y, cb: assign_cb, cr: operand[7:5]}
                };
            end
        end
    end

endmodule

//--- hw/graphics.sv
/* Graphics top level tying the command decoder, double buffer, palette
   and raster driver together. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module graphics import graphics_pkg::*; (
    input  logic       clock_in,
    input  logic       rst_n,
    input  logic [7:0] op_code,
    input  logic       op_code_valid,
    input  logic [7:0] operand,
    input  logic       operand_valid,
    input  logic [7:0] operand_count,
    output logic       display_clock,
    output logic       display_hsync,
    output logic       display_vsync,
    output logic [3:0] display_y,
    output logic [2:0] display_cb,
    output logic [2:0] display_cr
);

    pixel_write_t                pixel_write;
    color_assign_t               color_assign;
    logic                        show_request;
    logic                        frame_start;
    logic [`PIXEL_ADDR_BITS-1:0] read_address;
    logic [3:0]                  read_index;
    ycbcr_t                      pixel_color;
    display_pins_t               display_pins;

    command_decoder i_command_decoder (
        .clock_in,
        .rst_n,
        .op_code,
        .op_code_valid,
        .operand,
        .operand_valid,
        .operand_count,
        .pixel_write,
        .color_assign,
        .show_request
    );

    display_buffers i_display_buffers (
        .clock_in,
        .rst_n,
        .pixel_write,
        .show_request,
        .frame_start,
        .read_address,
        .read_index
    );

    color_palette i_color_palette (
        .clock_in,
        .rst_n,
        .color_assign,
        .pixel_index(read_index),
        .pixel_color
    );

    display_driver i_display_driver (
        .clock_in,
        .rst_n,
        .pixel_color,
        .read_address,
        .frame_start,
        .display_clock,
        .display_pins
    );

    assign display_hsync = display_pins.hsync;
    assign display_vsync = display_pins.vsync;
    assign display_y = display_pins.y;
    assign display_cb = display_pins.cb;
    assign display_cr = display_pins.cr;

endmodule

//--- run.sh
#!/bin/sh
# Builds the graphics testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module graphics_tb -f files.f &&
./obj_dir/Vgraphics_tb +verilator+error+limit+100 | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- testbench/graphics_sva.sv
/* Concurrent assertions on the decoder strobes, display sync and buffer swap. */
`timescale 1ns/1ps

module graphics_sva (
    input logic       clock_in,
    input logic       rst_n,
    input logic       pixel_write_valid,
    input logic       color_assign_valid,
    input logic       show_request,
    input logic       frame_start,
    input logic       front_select,
    input logic       display_hsync,
    input logic       display_vsync,
    input logic [3:0] display_y,
    input logic [2:0] display_cb,
    input logic [2:0] display_cr
);

    int failure_count = 0;

    pixel_write_strobe: assert property (@(posedge clock_in) disable iff (!rst_n)
        pixel_write_valid |=> !pixel_write_valid)
        else begin
            $error("pixel_write.valid held for more than one cycle.");
            failure_count++;
        end

    color_assign_strobe: assert property (@(posedge clock_in) disable iff (!rst_n)
        color_assign_valid |=> !color_assign_valid)
        else begin
            $error("color_assign.valid held for more than one cycle.");
            failure_count++;
        end

    show_strobe: assert property (@(posedge clock_in) disable iff (!rst_n)
        show_request |=> !show_request)
        else begin
            $error("show_request held for more than one cycle.");
            failure_count++;
        end

    // Colour must be black whenever a sync pulse is on the pins.
    sync_is_black: assert property (@(posedge clock_in) disable iff (!rst_n)
        (display_hsync || display_vsync) |-> {display_y, display_cb, display_cr} == '0)
        else begin
            $error("Nonzero colour while hsync or vsync is high.");
            failure_count++;
        end

    sync_rises_apart: assert property (@(posedge clock_in) disable iff (!rst_n)
        !($rose(display_hsync) && $rose(display_vsync)))
        else begin
            $error("hsync and vsync rose in the same clock.");
            failure_count++;
        end

    swap_at_frame_start: assert property (@(posedge clock_in) disable iff (!rst_n)
        !$stable(front_select) |-> $past(frame_start))
        else begin
            $error("Front buffer changed without a preceding frame_start.");
            failure_count++;
        end

endmodule

bind graphics graphics_sva i_graphics_sva (
    .clock_in,
    .rst_n,
    .pixel_write_valid(pixel_write.valid),
    .color_assign_valid(color_assign.valid),
    .show_request,
    .frame_start,
    .front_select(i_display_buffers.front_select),
    .display_hsync,
    .display_vsync,
    .display_y,
    .display_cb,
    .display_cr
);

//--- testbench/graphics_tb.sv
/* Directed testbench for the graphics subsystem with command tasks, a raster
   capture and a reference model of the palette and both frame buffers. */
`timescale 1ns/1ps
`include "graphics_params.svh"

module graphics_tb import graphics_pkg::*; ();

    localparam logic [31:0] SEED = 32'h7a69_9ab0;
    localparam int FRAME_TIMEOUT = 1200;    // A frame takes 440 clocks.
    localparam int CAPTURE_TIMEOUT = 2000;
    localparam int H_TOTAL = `FRAME_WIDTH + `H_BLANK;
    localparam int PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;

    logic       clock_in = 1'b0;
    logic       rst_n;
    logic [7:0] op_code;
    logic       op_code_valid;
    logic [7:0] operand;
    logic       operand_valid;
    logic [7:0] operand_count;
    logic       display_clock;
    logic       display_hsync;
    logic       display_vsync;
    logic [3:0] display_y;
    logic [2:0] display_cb;
    logic [2:0] display_cr;

    logic [31:0] lcg_state = SEED;
    logic [9:0]  model_palette [`PALETTE_SIZE];   // Packed {y, cb, cr}.
    logic [3:0]  model_buffer [2][PIXELS];
    logic        model_front;
    logic        model_pending;                   // Set by a show until the next vsync.

    graphics i_graphics (.*);

    always #50 clock_in = ~clock_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped after a failure.");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [3:0] pattern_index(input int kind, input int x, input int y);
        if (kind == 1) begin
            return 4'(x + y);
        end
        return (kind == 2) ? 4'(3 * x + 5 * y + 7) : 4'h0;
    endfunction

    task automatic start_command(input logic [7:0] code);
        @(posedge clock_in);
        op_code <= code;
        op_code_valid <= 1'b1;
    endtask

    task automatic end_command();
        @(posedge clock_in);
        op_code_valid <= 1'b0;
    endtask

    task automatic send_operand(input int position, input logic [7:0] value);
        @(posedge clock_in);
        operand <= value;
        operand_count <= 8'(position);
        operand_valid <= 1'b1;
        @(posedge clock_in);
        operand_valid <= 1'b0;
    endtask

    task automatic assign_color(input logic [3:0] index, input logic [9:0] color);
        start_command(OP_ASSIGN_COLOR);
        send_operand(1, {4'h0, index});
        send_operand(2, {color[9:6], 4'h0});   // Fields sit in the top bits of each byte.
        send_operand(3, {color[5:3], 5'h00});
        send_operand(4, {color[2:0], 5'h00});
        end_command();
        model_palette[index] = color;
    endtask

    task automatic draw_pixel(input int address, input logic [3:0] index);
        start_command(OP_DRAW_PIXEL);
        send_operand(1, 8'(address >> 8));
        send_operand(2, 8'(address));
        send_operand(3, {4'h0, index});
        end_command();
        model_buffer[!model_front][address] = index;
    endtask

    task automatic show_buffer();
        start_command(OP_SHOW_BUFFER);
        end_command();
        repeat (2) @(posedge clock_in);   // Lets the pending flag settle in the DUT.
        model_pending = 1'b1;
    endtask

    task automatic fill_back_buffer(input int kind);
        for (int y = 0; y < `FRAME_HEIGHT; y++) begin
            for (int x = 0; x < `FRAME_WIDTH; x++) begin
                draw_pixel(y * `FRAME_WIDTH + x, pattern_index(kind, x, y));
            end
        end
    endtask

    task automatic wait_frame_start();
        logic previous;
        int   clocks;
        @(negedge clock_in);
        clocks = 0;
        do begin
            previous = display_vsync;
            @(negedge clock_in);
            clocks++;
            if (clocks > FRAME_TIMEOUT) begin
                abort_run("Timeout while waiting for a rising edge of display_vsync.");
            end
        end while (!(display_vsync && !previous));
        if (model_pending) begin
            model_front = !model_front;
            model_pending = 1'b0;
        end
    endtask

    // Slot count restarts at each hsync fall, so the active pixels follow the blank tail.
    task automatic capture_frame();
        int         line;
        int         slot;
        int         hsync_width;
        int         vsync_width;
        int         active_pixels;
        int         clocks;
        int         x;
        int         y;
        logic       previous_clock;
        logic       previous_hsync;
        logic       previous_vsync;
        logic [9:0] expected;
        wait_frame_start();
        // The vsync line opens with the first clock of a slot.
        check("display_clock in the first clock of a slot", display_clock, 1'b0);
        line = 0;
        slot = 0;
        hsync_width = 0;
        vsync_width = 0;
        active_pixels = 0;
        clocks = 0;
        previous_clock = display_clock;
        previous_hsync = display_hsync;
        previous_vsync = display_vsync;
        while (line < `V_BLANK_LINES + `FRAME_HEIGHT) begin
            @(negedge clock_in);
            clocks++;
            if (clocks > CAPTURE_TIMEOUT) begin
                abort_run("Timeout while capturing a frame from the display pins.");
            end
            if (display_clock && !previous_clock) begin
                x = slot - (`H_BLANK - `HSYNC_SLOTS);
                y = line - `V_BLANK_LINES;
                expected = '0;   // Blanking slots stay black.
                if (x >= 0 && x < `FRAME_WIDTH && y >= 0 && y < `FRAME_HEIGHT) begin
                    expected = model_palette[model_buffer[model_front][y * `FRAME_WIDTH + x]];
                    active_pixels++;
                end
                check("{display_y, display_cb, display_cr}",
                      {display_y, display_cb, display_cr}, expected);
                slot++;
                if (display_hsync) begin
                    hsync_width++;
                end
                if (display_vsync) begin
                    vsync_width++;
                end
            end
            if (!display_hsync && previous_hsync) begin
                check("display_hsync width in display clocks", hsync_width, `HSYNC_SLOTS);
                hsync_width = 0;
                slot = 0;
                line++;
            end
            if (!display_vsync && previous_vsync) begin
                check("display_vsync width in display clocks", vsync_width,
                      `VSYNC_LINES * H_TOTAL);
            end
            previous_clock = display_clock;
            previous_hsync = display_hsync;
            previous_vsync = display_vsync;
        end
        check("active pixel count", active_pixels, PIXELS);
    endtask

    task automatic check_reset_outputs();
        @(negedge clock_in);
        check("display_clock", display_clock, 1'b0);
        check("display_hsync", display_hsync, 1'b0);
        check("display_vsync", display_vsync, 1'b0);
        check("{display_y, display_cb, display_cr}",
              {display_y, display_cb, display_cr}, 10'h000);
    endtask

    task automatic check_blank_after_reset();
        fill_back_buffer(0);
        show_buffer();
        capture_frame();
    endtask

    task automatic show_palette_image();
        for (int i = 0; i < `PALETTE_SIZE; i++) begin
            assign_color(4'(i), 10'(next_random() >> 22));
        end
        fill_back_buffer(1);
        show_buffer();
        capture_frame();
    endtask

    task automatic verify_double_buffering();
        fill_back_buffer(2);
        capture_frame();   // Still the old image.
        capture_frame();
        show_buffer();
        capture_frame();
    endtask

    task automatic change_palette_entry();
        assign_color(4'd5, ~model_palette[5]);
        capture_frame();
    endtask

    task automatic draw_random_pixels();
        logic [31:0] value;
        repeat (24) begin
            value = next_random();
            draw_pixel(int'((value >> 16) % PIXELS), value[27:24]);
        end
        show_buffer();
        capture_frame();
    endtask

    initial begin
        rst_n = 1'b0;
        op_code = '0;
        op_code_valid = 1'b0;
        operand = '0;
        operand_valid = 1'b0;
        operand_count = '0;
        model_front = 1'b0;
        model_pending = 1'b0;
        for (int i = 0; i < `PALETTE_SIZE; i++) begin
            model_palette[i] = '0;
        end
        for (int i = 0; i < PIXELS; i++) begin
            model_buffer[0][i] = '0;
            model_buffer[1][i] = '0;
        end
        repeat (7) @(posedge clock_in);
        check_reset_outputs();
        @(posedge clock_in);
        rst_n <= 1'b1;

        check_blank_after_reset();
        show_palette_image();
        verify_double_buffering();
        change_palette_entry();
        draw_random_pixels();

        if (i_graphics.i_graphics_sva.failure_count != 0) begin
            abort_run($sformatf("%0d concurrent assertion failures were reported.",
                                i_graphics.i_graphics_sva.failure_count));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule
